// File: source/riscboy_cfg.svh
/* riscboy board subsystem configuration
   pin widths, reset timing, pwm and heartbeat divisors */
`ifndef RISCBOY_CFG_SVH
`define RISCBOY_CFG_SVH

// gpio block
`define RISCBOY_GPIO_W 16 // pins on the gpio block

// set bits are routed to pads
// pin 0 stays inside as the led request
`define RISCBOY_GPIO_IS_PAD 16'hfffe

// register bus
`define RISCBOY_ADDR_W 2 // four registers

// reset generator
`define RISCBOY_RST_SHIFT 3 // synchronizer stages
`define RISCBOY_RST_COUNT 20 // hold cycles after sync, short for simulation

// rgb led driver
`define RISCBOY_PWM_W 4 // 16 cycle pwm period

// heartbeat half period in clk cycles
// a real board would want millions here
`define RISCBOY_BLINK_DIV 40

`endif

// File: source/riscboy_pkg.sv
/* riscboy board subsystem types
   register write port, pad drive and led configuration */
`default_nettype none

`include "riscboy_cfg.svh"

package riscboy_pkg;

	// plain vectors with a meaning
	typedef logic [`RISCBOY_GPIO_W-1:0] gpio_vec_t; // one bit per pin
	typedef logic [`RISCBOY_PWM_W-1:0]  pwm_duty_t; // high cycles per period
	typedef logic [`RISCBOY_ADDR_W-1:0] reg_addr_t; // register select

	// register write port, plain strobe
	typedef struct packed {
		logic      wr;    // single cycle write
		reg_addr_t addr;  // target register
		gpio_vec_t wdata; // write data
	} bus_wr_t;

	// pad drive towards the outside
	typedef struct packed {
		gpio_vec_t out; // output level
		gpio_vec_t oe;  // output enable
	} pad_out_t;

	// LEDCFG register layout
	// hb_sel is bit 12, duty_r sits in the low nibble
	typedef struct packed {
		logic      hb_sel; // blue follows heartbeat
		pwm_duty_t duty_b;
		pwm_duty_t duty_g;
		pwm_duty_t duty_r;
	} led_cfg_t;

	// led pins
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} led_out_t;

endpackage

`default_nettype wire

// File: source/fpga_reset.sv
/* board reset generator
   syncs the external reset and holds the core for a few more cycles */
`timescale 1ns/1ps
`default_nettype none

`include "riscboy_cfg.svh"

module fpga_reset (
	input  wire  clk,
	input  wire  arst_n,
	input  wire  force_rst_n, // low restarts the sequence
	output logic rst_n
);

	localparam int shift = `RISCBOY_RST_SHIFT;
	localparam int count = `RISCBOY_RST_COUNT;
	localparam int cnt_w = $clog2(count + 1); // must hold count itself

	logic [shift-1:0] sync_q; // shift chain, fills with ones
	logic [cnt_w-1:0] hold_q; // cycles since sync done
	logic             sync_done;

	assign sync_done = sync_q[shift-1]; // last stage of the chain

	// synchronizer chain
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[shift-2:0], force_rst_n}; // shift in at bit 0
		end
	end

	// hold counter, rst_n comes out registered
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hold_q <= '0;
			rst_n  <= 1'b0;
		end else if (!sync_done) begin
			// chain not full yet or force_rst_n dropped
			hold_q <= '0;
			rst_n  <= 1'b0;
		end else begin
			if (hold_q != cnt_w'(count)) begin
				hold_q <= hold_q + 1'b1; // saturates at count
			end
			rst_n <= (hold_q == cnt_w'(count)); // release after full hold
		end
	end

endmodule

`default_nettype wire

// File: source/gpio_regs.sv
/* gpio register file
   OUT, OE and LEDCFG registers, pad routing and synchronized read-back */
`timescale 1ns/1ps
`default_nettype none

`include "riscboy_cfg.svh"

module gpio_regs (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire riscboy_pkg::bus_wr_t   bus,
	input  wire riscboy_pkg::reg_addr_t rd_addr,
	input  wire riscboy_pkg::gpio_vec_t pad_in,
	output riscboy_pkg::gpio_vec_t      rd_data,
	output riscboy_pkg::pad_out_t       pads,
	output logic                        led_req,
	output riscboy_pkg::led_cfg_t       led_cfg
);

	import riscboy_pkg::*;

	localparam gpio_vec_t pad_mask = `RISCBOY_GPIO_IS_PAD;
	localparam int        gpio_w   = `RISCBOY_GPIO_W;
	localparam int        cfg_w    = $bits(led_cfg_t); // 13 bits used of the word

	// register map
	localparam reg_addr_t addr_out    = reg_addr_t'(0);
	localparam reg_addr_t addr_oe     = reg_addr_t'(1);
	localparam reg_addr_t addr_in     = reg_addr_t'(2); // read only
	localparam reg_addr_t addr_ledcfg = reg_addr_t'(3);

	gpio_vec_t out_q;     // OUT register
	gpio_vec_t oe_q;      // OE register
	led_cfg_t  ledcfg_q;  // LEDCFG register
	gpio_vec_t in_meta_q; // first sync stage
	gpio_vec_t in_q;      // IN register, second stage
	gpio_vec_t rd_mux;

	// register writes take effect on the strobe edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_q    <= '0;
			oe_q     <= '0; // all pads floating after reset
			ledcfg_q <= '0; // leds dark
		end else if (bus.wr) begin
			case (bus.addr)
				addr_out: begin
					out_q <= bus.wdata;
				end
				addr_oe: begin
					oe_q <= bus.wdata;
				end
				addr_ledcfg: begin
					ledcfg_q <= led_cfg_t'(bus.wdata[cfg_w-1:0]); // upper bits dropped
				end
				default: begin
					// writes to IN are ignored
				end
			endcase
		end
	end

	// pad inputs cross in through two flops
	always_ff @(posedge clk) begin
		in_meta_q <= pad_in;
		in_q      <= in_meta_q & pad_mask; // internal pins read 0
	end

	// read select
	always_comb begin
		case (rd_addr)
			addr_out: begin
				rd_mux = out_q;
			end
			addr_oe: begin
				rd_mux = oe_q;
			end
			addr_in: begin
				rd_mux = in_q;
			end
			addr_ledcfg: begin
				rd_mux = {{(gpio_w - cfg_w){1'b0}}, ledcfg_q}; // zero extended
			end
			default: begin
				rd_mux = '0;
			end
		endcase
	end

	// registered read-back, one cycle after rd_addr
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= rd_mux;
		end
	end

	// internal pins never reach the outside
	assign pads.out = out_q & pad_mask;
	assign pads.oe  = oe_q & pad_mask;

	// pin 0 is the on-board led request instead of a pad
	// needs both level and enable like a real pin would
	assign led_req = out_q[0] & oe_q[0];

	assign led_cfg = ledcfg_q; // straight to the led driver

endmodule

`default_nettype wire

// File: source/rgb_led_driver.sv
/* rgb led driver
   per-channel pwm, heartbeat divider and blue source select */
`timescale 1ns/1ps
`default_nettype none

`include "riscboy_cfg.svh"

module rgb_led_driver (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        led_req, // gpio pin 0
	input  wire riscboy_pkg::led_cfg_t led_cfg,
	output riscboy_pkg::led_out_t      leds
);

	import riscboy_pkg::*;

	localparam int div   = `RISCBOY_BLINK_DIV;
	localparam int div_w = $clog2(div);

	pwm_duty_t        pwm_cnt_q; // free running, wraps every 16
	logic [div_w-1:0] div_q;     // heartbeat prescaler
	logic             hb_q;      // heartbeat level
	logic             pwm_r;
	logic             pwm_g;
	logic             pwm_b;

	// pwm period counter
	// zero at reset release so the first period starts right away
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pwm_cnt_q <= '0;
		end else begin
			pwm_cnt_q <= pwm_cnt_q + 1'b1; // natural wrap
		end
	end

	// high while counter below duty
	assign pwm_r = (pwm_cnt_q < led_cfg.duty_r);
	assign pwm_g = (pwm_cnt_q < led_cfg.duty_g);
	assign pwm_b = (pwm_cnt_q < led_cfg.duty_b);

	// heartbeat divider, the blinky of the board
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			div_q <= '0;
			hb_q  <= 1'b0; // starts low
		end else if (div_q == div_w'(div - 1)) begin
			div_q <= '0;
			hb_q  <= ~hb_q; // half period done
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	// registered pins so the pads see no glitches
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			leds <= '0;
		end else begin
			leds.r <= pwm_r;
			leds.g <= pwm_g & led_req; // green is the gpio led
			leds.b <= led_cfg.hb_sel ? hb_q : pwm_b;
		end
	end

endmodule

`default_nettype wire

// File: source/riscboy_fpga.sv
/* riscboy board subsystem top level
   reset generator, gpio registers and rgb led driver */
`timescale 1ns/1ps
`default_nettype none

module riscboy_fpga (
	input  wire                         clk,
	input  wire                         arst_n,    // external board reset
	input  wire riscboy_pkg::bus_wr_t   bus,       // register writes
	input  wire riscboy_pkg::reg_addr_t rd_addr,   // register read select
	input  wire riscboy_pkg::gpio_vec_t pad_in,    // raw pad levels
	output wire riscboy_pkg::gpio_vec_t rd_data,   // registered read data
	output wire riscboy_pkg::pad_out_t  pads,      // pad out and oe
	output wire riscboy_pkg::led_out_t  leds,      // rgb led pins
	output wire                         sys_rst_n  // released core reset
);

	import riscboy_pkg::*;

	wire           led_req; // gpio pin 0 towards green
	wire led_cfg_t led_cfg; // LEDCFG register contents

	// core reset
	// sys_rst_n also resets the blocks below
	fpga_reset rstgen (
		.clk         (clk),
		.arst_n      (arst_n),
		.force_rst_n (1'b1), // no soft reset source here
		.rst_n       (sys_rst_n)
	);

	// gpio and led configuration registers
	gpio_regs gpio (
		.clk     (clk),
		.arst_n  (sys_rst_n),
		.bus     (bus),
		.rd_addr (rd_addr),
		.pad_in  (pad_in),
		.rd_data (rd_data),
		.pads    (pads),
		.led_req (led_req),
		.led_cfg (led_cfg)
	);

	// rgb led with heartbeat
	rgb_led_driver ledctl (
		.clk     (clk),
		.arst_n  (sys_rst_n),
		.led_req (led_req),
		.led_cfg (led_cfg),
		.leds    (leds)
	);

endmodule

`default_nettype wire

// File: testbench/tb_riscboy_fpga.sv
/* testbench for the riscboy board subsystem
   reset release, register table, pad mask, input sync, pwm duty and heartbeat */
`timescale 1ns/1ps
`default_nettype none

`include "riscboy_cfg.svh"

module tb_riscboy_fpga;

	import riscboy_pkg::*;

	localparam gpio_vec_t pad_mask       = `RISCBOY_GPIO_IS_PAD;
	localparam gpio_vec_t ledcfg_mask    = 16'h1fff; // 13 bit LEDCFG register
	localparam int        rst_cycles     = `RISCBOY_RST_SHIFT + `RISCBOY_RST_COUNT;
	localparam int        blink_div      = `RISCBOY_BLINK_DIV;
	localparam int        pwm_period     = 1 << `RISCBOY_PWM_W;
	localparam int        timeout_cycles = 2000; // run needs roughly 500 cycles

	typedef enum logic [1:0] {op_write, op_read, op_pad} op_t;

	// one stimulus step with its expected read value
	typedef struct packed {
		op_t       op;
		reg_addr_t addr;
		gpio_vec_t data;
		gpio_vec_t exp;
	} entry_t;

	logic      clk;
	logic      arst_n;
	bus_wr_t   bus;
	reg_addr_t rd_addr;
	gpio_vec_t pad_in;
	gpio_vec_t rd_data;
	pad_out_t  pads;
	led_out_t  leds;
	logic      sys_rst_n;

	entry_t    stim_q [$];     // stimulus table
	gpio_vec_t model_regs [4]; // register contents as the map defines them
	integer    seed = 32'h54a7;
	int        cycle_cnt = 0;

	// pwm cases, green needs pin 0 set and enabled
	int   duty_r_list [7] = '{3, 0, 15, 8, 5, 1, 12};
	int   duty_g_list [7] = '{9, 15, 0, 8, 7, 1, 4};
	logic pin_out_list [7] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1};
	logic pin_oe_list [7] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};

	riscboy_fpga u_riscboy_fpga (
		.clk       (clk),
		.arst_n    (arst_n),
		.bus       (bus),
		.rd_addr   (rd_addr),
		.pad_in    (pad_in),
		.rd_data   (rd_data),
		.pads      (pads),
		.leds      (leds),
		.sys_rst_n (sys_rst_n)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			report_failure($sformatf("** Error %s: expected %0h, actual %0h", name, exp, act));
		end
	endtask

	// watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			report_failure($sformatf("timeout, run did not finish in %0d cycles", timeout_cycles));
		end
	end

	function automatic void add_write(input reg_addr_t addr, input gpio_vec_t data);
		stim_q.push_back('{op_write, addr, data, '0});
		if (addr == 2'd3) begin
			model_regs[addr] = data & ledcfg_mask;
		end else if (addr != 2'd2) begin
			model_regs[addr] = data; // IN ignores writes
		end
	endfunction

	function automatic void add_read(input reg_addr_t addr);
		stim_q.push_back('{op_read, addr, '0, model_regs[addr]});
	endfunction

	function automatic void add_pad(input gpio_vec_t data);
		model_regs[2] = data & pad_mask; // internal pin reads 0
		stim_q.push_back('{op_pad, 2'd2, data, model_regs[2]});
	endfunction

	function automatic void build_table();
		gpio_vec_t val;
		for (int i = 0; i < 4; i++) begin
			model_regs[i] = '0;
		end
		add_write(2'd0, 16'ha5c3);
		add_read(2'd0);
		add_write(2'd1, 16'h0ff0);
		add_read(2'd1);
		add_read(2'd0); // OUT untouched by OE write
		add_write(2'd3, 16'hffff);
		add_read(2'd3); // upper bits dropped
		add_write(2'd3, 16'h1234);
		add_read(2'd3);
		add_write(2'd2, 16'hbeef); // read only, no effect
		add_read(2'd0);
		add_read(2'd1);
		for (int i = 0; i < 5; i++) begin
			val = gpio_vec_t'($random(seed));
			add_pad(val);
		end
		add_read(2'd2); // IN holds the last value
		add_write(2'd0, 16'h0000);
		add_read(2'd0);
	endfunction

	// all tasks below start and end on a falling edge
	task automatic apply_write(input reg_addr_t addr, input gpio_vec_t data);
		bus.wr    = 1'b1;
		bus.addr  = addr;
		bus.wdata = data;
		@(negedge clk); // write edge passed
		bus.wr = 1'b0;
	endtask

	task automatic check_read(input string name, input reg_addr_t addr, input gpio_vec_t exp);
		rd_addr = addr;
		@(negedge clk); // rd_data registered
		check_value(name, exp, rd_data);
	endtask

	task automatic drive_pad(input string name, input gpio_vec_t data, input gpio_vec_t exp);
		pad_in  = data;
		rd_addr = 2'd2;
		repeat (3) @(negedge clk); // two sync flops plus read register
		check_value(name, exp, rd_data);
	endtask

	task automatic count_high(output int cnt_r, output int cnt_g, output int cnt_b);
		cnt_r = 0;
		cnt_g = 0;
		cnt_b = 0;
		repeat (pwm_period) begin
			@(negedge clk);
			cnt_r += leds.r;
			cnt_g += leds.g;
			cnt_b += leds.b;
		end
	endtask

	task automatic run_pwm(input int idx, input int dr, input int dg, input logic pin_out,
			input logic pin_oe);
		int db;
		int exp_g;
		int cnt_r;
		int cnt_g;
		int cnt_b;
		db    = pwm_period - 1 - dr;
		exp_g = (pin_out && pin_oe) ? dg : 0; // green only with the led request
		apply_write(2'd0, pad_mask | pin_out);
		apply_write(2'd1, pad_mask | pin_oe);
		apply_write(2'd3, {4'b0000, pwm_duty_t'(db), pwm_duty_t'(dg), pwm_duty_t'(dr)});
		count_high(cnt_r, cnt_g, cnt_b); // first sample already on new config
		check_value($sformatf("pwm case %0d red", idx), dr, cnt_r);
		check_value($sformatf("pwm case %0d green", idx), exp_g, cnt_g);
		check_value($sformatf("pwm case %0d blue", idx), db, cnt_b);
	endtask

	task automatic wait_blue_toggle(output int cycles);
		logic prev;
		int   n;
		prev = leds.b;
		n    = 0;
		while (leds.b == prev && n < 2 * blink_div) begin
			@(negedge clk);
			n++;
		end
		if (leds.b == prev) begin
			report_failure($sformatf("blue heartbeat did not toggle within %0d cycles", n));
		end
		cycles = n;
	endtask

	initial begin
		int gap;
		arst_n  = 1'b0;
		bus     = '0;
		rd_addr = '0;
		pad_in  = '0;
		build_table();

		repeat (2) @(negedge clk); // reset for 2 cycles
		check_value("sys_rst_n in reset", 0, sys_rst_n);
		arst_n = 1'b1;

		// release lands exactly on edge rst_cycles + 1
		for (int i = 1; i <= rst_cycles + 1; i++) begin
			@(negedge clk);
			check_value($sformatf("sys_rst_n after edge %0d", i), (i > rst_cycles), sys_rst_n);
		end
		check_value("pads.oe after reset", 0, pads.oe);
		check_value("leds after reset", 0, leds);
		check_value("led_req after reset", 0, u_riscboy_fpga.led_req);

		foreach (stim_q[i]) begin
			case (stim_q[i].op)
				op_write: apply_write(stim_q[i].addr, stim_q[i].data);
				op_read: check_read($sformatf("entry %0d read addr %0d", i, stim_q[i].addr),
					stim_q[i].addr, stim_q[i].exp);
				default: drive_pad($sformatf("entry %0d pad_in %h", i, stim_q[i].data),
					stim_q[i].data, stim_q[i].exp);
			endcase
		end

		// pad mask, pin 0 stays inside
		apply_write(2'd0, 16'hffff);
		apply_write(2'd1, 16'hffff);
		check_value("pads.out all ones", pad_mask, pads.out);
		check_value("pads.oe all ones", pad_mask, pads.oe);
		check_value("led_req all ones", 1, u_riscboy_fpga.led_req);

		for (int i = 0; i < 7; i++) begin
			run_pwm(i, duty_r_list[i], duty_g_list[i], pin_out_list[i], pin_oe_list[i]);
		end

		// heartbeat replaces blue
		apply_write(2'd3, 16'h1000);
		@(negedge clk); // leds.b now from the divider
		wait_blue_toggle(gap); // phase unknown, first edge only aligns
		for (int i = 0; i < 3; i++) begin
			wait_blue_toggle(gap);
			check_value($sformatf("heartbeat interval %0d", i), blink_div, gap);
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// File: riscboy_fpga.f
+incdir+source
source/riscboy_pkg.sv
source/fpga_reset.sv
source/gpio_regs.sv
source/rgb_led_driver.sv
source/riscboy_fpga.sv
testbench/tb_riscboy_fpga.sv

// File: Bender.yml
package:
  name: riscboy_fpga

sources:
  # board subsystem RTL
  - include_dirs:
      - source
    files:
      - source/riscboy_pkg.sv
      - source/fpga_reset.sv
      - source/gpio_regs.sv
      - source/rgb_led_driver.sv
      - source/riscboy_fpga.sv

  # testbench, top module tb_riscboy_fpga
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_riscboy_fpga.sv
